/* drawPkg.sv */
package drawPkg;

    ////////////////////////////////////////
    // Screen geometry and basic types.
    ////////////////////////////////////////
    localparam int SCREEN_W = 64;             // Pixels per row.
    localparam int SCREEN_H = 32;             // Rows per frame.

    typedef logic [23:0] sdramAddr_t;         // Linear pixel address, y * SCREEN_W + x.
    typedef logic [15:0] rgb565_t;
    typedef logic [5:0]  coord_t;             // One screen coordinate.
    typedef logic [6:0]  extent_t;            // Width or height up to 64.
    typedef logic [39:0] bcd_t;               // Ten digits with digit 9 on top.

    // Palette.
    localparam rgb565_t COLOR_BLACK       = 16'h0000;
    localparam rgb565_t COLOR_WHITE       = 16'hFFFF;
    localparam rgb565_t COLOR_TITLE       = 16'h001F;   // Blue bar.
    localparam rgb565_t COLOR_ICON_DIM    = 16'h4208;   // Dark grey.
    localparam rgb565_t COLOR_ICON_ACTIVE = 16'h07E0;   // Green.

    ////////////////////////////////////////
    // Layout.
    ////////////////////////////////////////
    localparam coord_t  COUNT_X     = 6'd2;   // Latched count origin.
    localparam coord_t  COUNT_Y     = 6'd4;
    localparam coord_t  ACCUM_X     = 6'd2;   // Accumulated count origin.
    localparam coord_t  ACCUM_Y     = 6'd12;
    localparam coord_t  ICON_Y      = 6'd22;
    localparam coord_t  ICON_X0     = 6'd2;
    localparam coord_t  ICON_PITCH  = 6'd14;
    localparam extent_t ICON_W      = 7'd12;
    localparam extent_t ICON_H      = 7'd6;
    localparam extent_t TITLE_H     = 7'd2;
    localparam coord_t  DIGIT_PITCH = 6'd4;   // Glyph plus one blank column.

    // 3x5 font. Each row is {col2, col1, col0} and rows are listed bottom first.
    localparam logic [9:0][14:0] FONT = {
        15'b111_100_111_101_111,              // 9
        15'b111_101_111_101_111,              // 8
        15'b100_100_100_100_111,              // 7
        15'b111_101_111_001_111,              // 6
        15'b111_100_111_001_111,              // 5
        15'b100_100_111_101_101,              // 4
        15'b111_100_111_100_111,              // 3
        15'b111_001_111_100_111,              // 2
        15'b111_010_010_011_010,              // 1
        15'b111_101_101_101_111               // 0
    };

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        extent_t w;
        extent_t h;
        rgb565_t color;
    } rect_t;

    typedef struct packed {
        sdramAddr_t addr;
        rgb565_t    data;
    } pixelWr_t;

    typedef enum logic [3:0] {
        S_CLEAR, S_CLEAR_WAIT, S_TITLE, S_TITLE_WAIT,
        S_ICON, S_ICON_WAIT,
        S_COUNT_CONV, S_COUNT_WAIT, S_COUNT_BLIT,
        S_ACCUM_CONV, S_ACCUM_WAIT, S_ACCUM_BLIT
    } seqState_t;

    // Linear frame-buffer address of one pixel.
    function automatic sdramAddr_t pixelAddr(coord_t x, coord_t y);
        return sdramAddr_t'(y) * sdramAddr_t'(SCREEN_W) + sdramAddr_t'(x);
    endfunction

endpackage

/* drawSequencer.sv */
`timescale 1ns/1ps

module drawSequencer import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [1:0]  mode,
    input  logic [31:0] pulseCount,
    input  logic        dataUpdate,
    input  logic [31:0] accumCount,
    output logic        rectStart,
    output rect_t       rect,
    input  logic        rectDone,
    output logic        bcdStart,
    output logic [31:0] bcdValue,
    input  logic        bcdDone,
    output logic        glyphStart,
    output coord_t      glyphX,
    output coord_t      glyphY,
    input  logic        glyphDone,
    output logic        frameDone
);

    seqState_t   state;
    logic [31:0] latchedCount;   // Count shown in the upper row.
    logic [1:0]  iconIdx;        // Icon being drawn, 0 is leftmost.
    logic [1:0]  modeQ;          // Mode sampled at the first icon.
    logic [1:0]  activeMode;

    // First icon uses the live mode, the rest use the sampled copy.
    assign activeMode = (iconIdx == 2'd0) ? mode : modeQ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latchedCount <= '0;
        end else if (dataUpdate) begin
            latchedCount <= pulseCount;   // Latch new pulse count.
        end
    end

    ////////////////////////////////////////
    // Command FSM.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_CLEAR;
            iconIdx    <= '0;
            rectStart  <= 1'b0;
            bcdStart   <= 1'b0;
            glyphStart <= 1'b0;
            frameDone  <= 1'b0;
        end else begin
            rectStart  <= 1'b0;   // Starts are single pulses.
            bcdStart   <= 1'b0;
            glyphStart <= 1'b0;
            frameDone  <= 1'b0;
            case (state)
                // Issue states wait for en, wait states always finish.
                S_CLEAR:      if (en) begin
                    rectStart <= 1'b1;
                    state     <= S_CLEAR_WAIT;
                end
                S_CLEAR_WAIT: if (rectDone) state <= S_TITLE;
                S_TITLE:      if (en) begin
                    rectStart <= 1'b1;
                    state     <= S_TITLE_WAIT;
                end
                S_TITLE_WAIT: if (rectDone) state <= S_ICON;
                S_ICON:       if (en) begin
                    rectStart <= 1'b1;
                    state     <= S_ICON_WAIT;
                end
                S_ICON_WAIT:  if (rectDone) begin
                    iconIdx <= iconIdx + 2'd1;   // Wraps for next pass.
                    state   <= (iconIdx == 2'd3) ? S_COUNT_CONV : S_ICON;
                end
                S_COUNT_CONV: if (en) begin
                    bcdStart <= 1'b1;
                    state    <= S_COUNT_WAIT;
                end
                S_COUNT_WAIT: if (bcdDone) begin
                    glyphStart <= 1'b1;   // Digits are ready, blit them.
                    state      <= S_COUNT_BLIT;
                end
                S_COUNT_BLIT: if (glyphDone) state <= S_ACCUM_CONV;
                S_ACCUM_CONV: if (en) begin
                    bcdStart <= 1'b1;
                    state    <= S_ACCUM_WAIT;
                end
                S_ACCUM_WAIT: if (bcdDone) begin
                    glyphStart <= 1'b1;
                    state      <= S_ACCUM_BLIT;
                end
                S_ACCUM_BLIT: if (glyphDone) begin
                    frameDone <= 1'b1;    // Pass complete.
                    state     <= S_ICON;
                end
                default: state <= S_CLEAR;
            endcase
        end
    end

    ////////////////////////////////////////
    // Payloads loaded with each start.
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (state)
            S_CLEAR: if (en) begin
                rect <= '{x: '0, y: '0, w: extent_t'(SCREEN_W),
                          h: extent_t'(SCREEN_H), color: COLOR_BLACK};
            end
            S_TITLE: if (en) begin
                rect <= '{x: '0, y: '0, w: extent_t'(SCREEN_W),
                          h: TITLE_H, color: COLOR_TITLE};
            end
            S_ICON: if (en) begin
                if (iconIdx == 2'd0) begin
                    modeQ <= mode;
                end
                rect.x     <= ICON_X0 + iconIdx * ICON_PITCH;
                rect.y     <= ICON_Y;
                rect.w     <= ICON_W;
                rect.h     <= ICON_H;
                rect.color <= (activeMode == iconIdx) ? COLOR_ICON_ACTIVE : COLOR_ICON_DIM;
            end
            S_COUNT_CONV: if (en) bcdValue <= latchedCount;
            S_ACCUM_CONV: if (en) bcdValue <= accumCount;
            S_COUNT_WAIT: begin
                glyphX <= COUNT_X;
                glyphY <= COUNT_Y;
            end
            S_ACCUM_WAIT: begin
                glyphX <= ACCUM_X;
                glyphY <= ACCUM_Y;
            end
            default: ;
        endcase
    end

endmodule

/* rectFiller.sv */
`timescale 1ns/1ps

module rectFiller import drawPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  rect_t    rect,
    output logic     pixReq,
    output pixelWr_t pixOut,
    input  logic     pixAck,
    output logic     done
);

    rect_t  rectQ;     // Rectangle under fill.
    coord_t xOff;      // Offset inside the rectangle.
    coord_t yOff;
    logic   busy;
    logic   lastCol;
    logic   lastRow;

    assign lastCol = (extent_t'(xOff) == rectQ.w - 7'd1);
    assign lastRow = (extent_t'(yOff) == rectQ.h - 7'd1);

    // Raster walk, one step per acknowledged pixel.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            xOff <= '0;
            yOff <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                xOff <= '0;
                yOff <= '0;
            end else if (busy && pixAck) begin
                if (lastCol) begin
                    xOff <= '0;
                    if (lastRow) begin
                        busy <= 1'b0;   // Last pixel written.
                        done <= 1'b1;
                    end else begin
                        yOff <= yOff + 6'd1;
                    end
                end else begin
                    xOff <= xOff + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) rectQ <= rect;
    end

    assign pixReq      = busy;   // Held until the last acknowledge.
    assign pixOut.addr = pixelAddr(rectQ.x + xOff, rectQ.y + yOff);
    assign pixOut.data = rectQ.color;

endmodule

/* bcdConverter.sv */
`timescale 1ns/1ps

module bcdConverter import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [31:0] value,
    output bcd_t        digits,
    output logic        done
);

    logic [31:0] shiftReg;   // Binary bits still to shift in.
    logic [4:0]  bitCnt;
    logic        busy;
    bcd_t        adjusted;

    // Add 3 to each digit of 5 or more before the shift.
    always_comb begin
        adjusted = digits;
        for (int i = 0; i < 10; i++) begin
            if (digits[4*i +: 4] >= 4'd5) begin
                adjusted[4*i +: 4] = digits[4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            bitCnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy   <= 1'b1;
                bitCnt <= '0;
            end else if (busy) begin
                bitCnt <= bitCnt + 5'd1;
                if (bitCnt == 5'd31) begin   // 32nd shift.
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Digits stay put once busy drops.
    always_ff @(posedge clk) begin
        if (start) begin
            shiftReg <= value;
            digits   <= '0;
        end else if (busy) begin
            digits   <= {adjusted[38:0], shiftReg[31]};
            shiftReg <= {shiftReg[30:0], 1'b0};
        end
    end

endmodule

/* glyphBlitter.sv */
`timescale 1ns/1ps

module glyphBlitter import drawPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  coord_t   originX,
    input  coord_t   originY,
    input  bcd_t     digits,
    output logic     pixReq,
    output pixelWr_t pixOut,
    input  logic     pixAck,
    output logic     done
);

    coord_t     originXq;
    coord_t     originYq;
    logic [3:0] digitIdx;   // Cell position, 0 is leftmost.
    logic [2:0] row;        // 0 to 4 inside the cell.
    logic [1:0] col;        // 0 to 2 inside the cell.
    logic       busy;
    logic [3:0] curDigit;
    logic       fontBit;
    coord_t     px;
    coord_t     py;

    // Leftmost cell shows the most significant digit.
    assign curDigit = digits[4 * (9 - digitIdx) +: 4];
    assign fontBit  = FONT[curDigit][row * 3 + col];
    assign px       = originXq + digitIdx * DIGIT_PITCH + coord_t'(col);
    assign py       = originYq + coord_t'(row);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            digitIdx <= '0;
            row      <= '0;
            col      <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                digitIdx <= '0;
                row      <= '0;
                col      <= '0;
            end else if (busy && pixAck) begin
                if (col == 2'd2) begin
                    col <= '0;
                    if (row == 3'd4) begin
                        row <= '0;
                        if (digitIdx == 4'd9) begin
                            busy <= 1'b0;   // 150th pixel written.
                            done <= 1'b1;
                        end else begin
                            digitIdx <= digitIdx + 4'd1;
                        end
                    end else begin
                        row <= row + 3'd1;
                    end
                end else begin
                    col <= col + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            originXq <= originX;
            originYq <= originY;
        end
    end

    assign pixReq      = busy;
    assign pixOut.addr = pixelAddr(px, py);
    assign pixOut.data = fontBit ? COLOR_WHITE : COLOR_BLACK;   // Off pixels cleared too.

endmodule

/* sdramWritePort.sv */
`timescale 1ns/1ps

module sdramWritePort import drawPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rectReq,
    input  pixelWr_t   rectPix,
    input  logic       glyphReq,
    input  pixelWr_t   glyphPix,
    output logic       rectAck,
    output logic       glyphAck,
    output logic       sdramWrReq,
    output sdramAddr_t sdramWrAddr,
    output rgb565_t    sdramWrData,
    input  logic       sdramWrDone
);

    logic     grantGlyph;   // Owner of the write in flight.
    pixelWr_t selPix;

    assign selPix = rectReq ? rectPix : glyphPix;   // Rect filler wins.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdramWrReq <= 1'b0;
            grantGlyph <= 1'b0;
        end else if (!sdramWrReq) begin
            if (rectReq || glyphReq) begin
                sdramWrReq <= 1'b1;
                grantGlyph <= !rectReq;
            end
        end else if (sdramWrDone) begin
            sdramWrReq <= 1'b0;   // One idle cycle lets the owner step.
        end
    end

    // Pixel captured while idle, held for the whole write.
    always_ff @(posedge clk) begin
        if (!sdramWrReq) begin
            sdramWrAddr <= selPix.addr;
            sdramWrData <= selPix.data;
        end
    end

    assign rectAck  = sdramWrReq && sdramWrDone && !grantGlyph;
    assign glyphAck = sdramWrReq && sdramWrDone && grantGlyph;

endmodule

/* drawTop.sv */
`timescale 1ns/1ps

module drawTop import drawPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [1:0]  mode,
    input  logic [31:0] pulseCount,
    input  logic        dataUpdate,
    input  logic [31:0] accumCount,
    output logic        sdramWrReq,
    output sdramAddr_t  sdramWrAddr,
    output rgb565_t     sdramWrData,
    input  logic        sdramWrDone,
    output logic        frameDone
);

    ////////////////////////////////////////
    // Sequencer to datapath.
    ////////////////////////////////////////
    logic        rectStart;
    rect_t       rect;
    logic        rectDone;
    logic        bcdStart;
    logic [31:0] bcdValue;
    logic        bcdDone;
    bcd_t        digits;
    logic        glyphStart;
    coord_t      glyphX;
    coord_t      glyphY;
    logic        glyphDone;

    // Datapath to write port.
    logic        rectReq;
    pixelWr_t    rectPix;
    logic        rectAck;
    logic        glyphReq;
    pixelWr_t    glyphPix;
    logic        glyphAck;

    drawSequencer uSeq (
        .clk(clk), .rst_n(rst_n), .en(en), .mode(mode),
        .pulseCount(pulseCount), .dataUpdate(dataUpdate), .accumCount(accumCount),
        .rectStart(rectStart), .rect(rect), .rectDone(rectDone),
        .bcdStart(bcdStart), .bcdValue(bcdValue), .bcdDone(bcdDone),
        .glyphStart(glyphStart), .glyphX(glyphX), .glyphY(glyphY),
        .glyphDone(glyphDone), .frameDone(frameDone)
    );

    rectFiller uRect (
        .clk(clk), .rst_n(rst_n), .start(rectStart), .rect(rect),
        .pixReq(rectReq), .pixOut(rectPix), .pixAck(rectAck), .done(rectDone)
    );

    bcdConverter uBcd (
        .clk(clk), .rst_n(rst_n), .start(bcdStart), .value(bcdValue),
        .digits(digits), .done(bcdDone)
    );

    glyphBlitter uGlyph (
        .clk(clk), .rst_n(rst_n), .start(glyphStart), .originX(glyphX),
        .originY(glyphY), .digits(digits), .pixReq(glyphReq), .pixOut(glyphPix),
        .pixAck(glyphAck), .done(glyphDone)
    );

    sdramWritePort uPort (
        .clk(clk), .rst_n(rst_n),
        .rectReq(rectReq), .rectPix(rectPix), .glyphReq(glyphReq), .glyphPix(glyphPix),
        .rectAck(rectAck), .glyphAck(glyphAck),
        .sdramWrReq(sdramWrReq), .sdramWrAddr(sdramWrAddr),
        .sdramWrData(sdramWrData), .sdramWrDone(sdramWrDone)
    );

endmodule

/* drawTb.sv */
`timescale 1ns/1ps

module drawTb import drawPkg::*; ();

    ////////////////////////////////////////
    // Run limits.
    ////////////////////////////////////////
    localparam logic [31:0] SEED = 32'h2ef5_1430;
    localparam int FB_WORDS     = SCREEN_W * SCREEN_H;   // 2048 pixels.
    localparam int TEST_FRAMES  = 18;                    // Frames waited by all tests.
    localparam int FRAME_WRITES = 2600;                  // Generous writes per frame.
    localparam int WRITE_CYCLES = 5;                     // Worst case per write.
    localparam int IDLE_CYCLES  = 4000;                  // Reset and en-low windows.
    localparam int MAX_CYCLES   = (TEST_FRAMES + 1) * FRAME_WRITES * WRITE_CYCLES
                                  + IDLE_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic [1:0]  mode;
    logic [31:0] pulseCount;
    logic        dataUpdate;
    logic [31:0] accumCount;
    logic        sdramWrReq;
    sdramAddr_t  sdramWrAddr;
    rgb565_t     sdramWrData;
    logic        sdramWrDone;
    logic        frameDone;

    rgb565_t     frameBuf [FB_WORDS];   // Memory model contents.
    rgb565_t     refFrame [FB_WORDS];   // Expected image.
    logic [1:0]  expMode;               // Inputs the image should show.
    logic [31:0] expCount;
    logic [31:0] expAccum;
    string       testName;
    logic        checkReq;              // Main process asks for a compare.
    int          errorCount  = 0;
    int          addrErrors  = 0;
    int          testErrStart;
    int          testsRun    = 0;
    int          testsFailed = 0;

    drawTop DUT (
        .clk(clk), .rst_n(rst_n), .en(en), .mode(mode),
        .pulseCount(pulseCount), .dataUpdate(dataUpdate), .accumCount(accumCount),
        .sdramWrReq(sdramWrReq), .sdramWrAddr(sdramWrAddr), .sdramWrData(sdramWrData),
        .sdramWrDone(sdramWrDone), .frameDone(frameDone)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period.
    end

    ////////////////////////////////////////
    // Reference image.
    ////////////////////////////////////////
    function automatic void drawDigits(logic [31:0] value, int ox, int oy);
        logic [3:0]  dec [10];   // Index 0 is the least significant digit.
        logic [31:0] rest;
        int          px;
        rest = value;
        for (int k = 0; k < 10; k++) begin
            dec[k] = 4'(rest % 10);
            rest   = rest / 10;
        end
        for (int c = 0; c < 10; c++) begin   // Cell 0 leftmost, holds digit 9.
            for (int r = 0; r < 5; r++) begin
                for (int col = 0; col < 3; col++) begin
                    px = ox + c * int'(DIGIT_PITCH) + col;
                    refFrame[(oy + r) * SCREEN_W + px] =
                        FONT[dec[9 - c]][r * 3 + col] ? COLOR_WHITE : COLOR_BLACK;
                end
            end
        end
    endfunction

    function automatic void expectedImage(logic [1:0] m, logic [31:0] count,
                                          logic [31:0] accum);
        int base;
        for (int a = 0; a < FB_WORDS; a++) begin
            refFrame[a] = COLOR_BLACK;   // Cleared background.
        end
        for (int a = 0; a < int'(TITLE_H) * SCREEN_W; a++) begin
            refFrame[a] = COLOR_TITLE;   // Title rows span the full width.
        end
        for (int i = 0; i < 4; i++) begin
            base = int'(ICON_Y) * SCREEN_W + int'(ICON_X0) + i * int'(ICON_PITCH);
            for (int y = 0; y < int'(ICON_H); y++) begin
                for (int x = 0; x < int'(ICON_W); x++) begin
                    refFrame[base + y * SCREEN_W + x] =
                        (i == int'(m)) ? COLOR_ICON_ACTIVE : COLOR_ICON_DIM;
                end
            end
        end
        drawDigits(count, int'(COUNT_X), int'(COUNT_Y));
        drawDigits(accum, int'(ACCUM_X), int'(ACCUM_Y));
    endfunction

    ////////////////////////////////////////
    // SDRAM model, 0 to 3 wait cycles.
    ////////////////////////////////////////
    initial begin : sdramModel
        int   delayLeft;
        logic pending;
        for (int a = 0; a < FB_WORDS; a++) begin
            frameBuf[a] = rgb565_t'(a * 40503 + 23100);   // Junk so the clear shows.
        end
        pending   = 1'b0;
        delayLeft = 0;
        forever begin
            @(negedge clk);
            if (sdramWrDone) begin
                sdramWrDone = 1'b0;   // One-cycle done pulse.
            end else if (sdramWrReq) begin
                if (!pending) begin
                    pending   = 1'b1;
                    delayLeft = $urandom % 4;
                end
                if (delayLeft == 0) begin
                    assert (sdramWrAddr < FB_WORDS) else begin
                        addrErrors++;
                        $display("ERROR: write address %0d lies outside the frame buffer",
                                 sdramWrAddr);
                    end
                    if (sdramWrAddr < FB_WORDS) begin
                        frameBuf[sdramWrAddr[10:0]] = sdramWrData;
                    end
                    sdramWrDone = 1'b1;
                    pending     = 1'b0;
                end else begin
                    delayLeft--;
                end
            end
        end
    end

    // Full-frame compare, half a cycle after the request.
    always @(posedge clk) begin : compareFrame
        int shown;
        if (checkReq) begin
            shown = 0;
            expectedImage(expMode, expCount, expAccum);
            for (int a = 0; a < FB_WORDS; a++) begin
                assert (frameBuf[a] === refFrame[a]) else begin
                    errorCount++;
                    if (shown < 4) begin
                        $display("FAIL %s pixel (%0d,%0d): expected %h, actual %h", testName,
                                 a % SCREEN_W, a / SCREEN_W, refFrame[a], frameBuf[a]);
                    end
                    shown++;
                end
            end
            checkReq = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers.
    ////////////////////////////////////////
    task automatic beginTest(input string name);
        testName     = name;
        testErrStart = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount == testErrStart) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", testName, errorCount - testErrStart);
        end
    endtask

    task automatic waitFrames(input int n);
        int left;
        left = n;
        while (left > 0) begin
            @(negedge clk);
            if (frameDone) left--;
        end
    endtask

    task automatic checkImage();
        checkReq = 1'b1;
        wait (!checkReq);
        @(negedge clk);   // Back on the drive edge.
    endtask

    task automatic latchCount(input logic [31:0] value);
        pulseCount = value;
        dataUpdate = 1'b1;
        @(negedge clk);
        dataUpdate = 1'b0;
        pulseCount = ~value;   // Ignored until the next update.
        expCount   = value;
    endtask

    ////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////
    initial begin : stimulus
        logic [31:0] seedDummy;
        int          quiet;
        seedDummy   = $urandom(SEED);
        rst_n       = 1'b0;
        en          = 1'b1;
        mode        = 2'd0;
        pulseCount  = '0;
        dataUpdate  = 1'b0;
        accumCount  = '0;
        sdramWrDone = 1'b0;
        checkReq    = 1'b0;
        expMode     = 2'd0;
        expCount    = '0;
        expAccum    = '0;

        beginTest("reset outputs");
        repeat (10) begin
            @(negedge clk);
            assert (!sdramWrReq && !frameDone) else begin
                errorCount++;
                $display("ERROR: %s: request or frame pulse active in reset", testName);
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        assert (!sdramWrReq) else begin
            errorCount++;
            $display("ERROR: %s: SDRAM request high right after reset", testName);
        end
        endTest();

        beginTest("boot frame");
        waitFrames(2);
        checkImage();
        endTest();

        beginTest("random count");
        latchCount($urandom);
        waitFrames(2);
        checkImage();
        endTest();

        beginTest("max count");
        latchCount(32'hFFFF_FFFF);
        waitFrames(2);
        checkImage();
        endTest();

        for (int m = 1; m <= 4; m++) begin   // Modes 1, 2, 3 then back to 0.
            beginTest($sformatf("mode %0d", m % 4));
            mode    = 2'(m % 4);
            expMode = 2'(m % 4);
            waitFrames(2);
            checkImage();
            endTest();
        end

        beginTest("accumulated count");
        accumCount = $urandom;
        expAccum   = accumCount;
        pulseCount = $urandom;   // No update, latched value stays.
        waitFrames(2);
        checkImage();
        endTest();

        beginTest("enable low");
        en    = 1'b0;
        quiet = 0;
        while (quiet < 100) begin   // Let the running command finish.
            @(negedge clk);
            if (sdramWrReq) quiet = 0;
            else quiet++;
        end
        repeat (1000) begin
            @(negedge clk);
            assert (!sdramWrReq && !frameDone) else begin
                errorCount++;
                $display("ERROR: %s: memory write or frame pulse while en is low", testName);
            end
        end
        en = 1'b1;
        waitFrames(2);
        checkImage();
        endTest();

        beginTest("address range");
        assert (addrErrors == 0) else begin
            errorCount++;
            $display("ERROR: %0d writes went outside the frame buffer", addrErrors);
        end
        endTest();

        $display("summary: %0d tests, %0d failed, %0d errors",
                 testsRun, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Hang guard.
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* all.f */
drawPkg.sv
drawSequencer.sv
rectFiller.sv
bcdConverter.sv
glyphBlitter.sv
sdramWritePort.sv
drawTop.sv
drawTb.sv

/* run.sh */
#!/bin/sh
# Build and run the drawing subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module drawTb -f all.f -o drawTbSim
./obj_dir/drawTbSim | tee sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log
echo "Simulation finished without failures."
